/* conv_defines.svh */
/* Build-time sizes of the convolution layer. Image side is capped at MAX_IMG
   and the filter is fixed at 3x3. N_CORE must fit in CORE_BITS */
`ifndef CONV_DEFINES_SVH
`define CONV_DEFINES_SVH

`define DWIDTH 16   // Pixel, weight, result
`define PWIDTH 32   // Product and running sum
`define FRAC 8      // Fixed-point shift on each sum

`define MAX_IMG 8   // Largest image side
`define LWIDTH 4    // Size field
`define FIL 3       // Filter side
`define FIL_TAPS 9  // FIL * FIL

`define N_CORE 2    // Processing cores
`define CORE_BITS 1 // Core select

`define INSIZE 6    // Input memory address, 64 words
`define OUTSIZE 6   // Output memory address
`define WSIZE 4     // Weight memory address
`define CONV_LAT 4  // Pixel address to result ready

`endif

/* conv_pkg.sv */
/* Shared types of the convolution layer. Host ports and the control bus are
   packed structs, the window is a packed array with element 8 the newest pixel */
`include "conv_defines.svh"

package conv_pkg;

  typedef enum logic [2:0] {
    ST_IDLE,  // Host owns the memories
    ST_LOAD,  // Filter taps into core registers
    ST_FEED,  // Pixels streaming
    ST_DRAIN, // Windows still in flight
    ST_DONE   // Ack pulse
  } ctrl_state_e;

  typedef struct packed {
    logic               we;
    logic [`INSIZE-1:0] addr;
    logic [`DWIDTH-1:0] data;
  } input_wr_t;

  typedef struct packed {
    logic                  we;
    logic [`CORE_BITS-1:0] core; // Target core memory
    logic [`WSIZE-1:0]     addr; // Tap index
    logic [`DWIDTH-1:0]    data;
  } weight_wr_t;

  typedef struct packed {
    logic [`CORE_BITS-1:0] core;
    logic [`OUTSIZE-1:0]   addr;
  } out_rd_t;

  typedef struct packed {
    logic                buf_en;   // Pixel into line buffer
    logic                wreg_we;  // Weight into filter registers
    logic                out_we;   // Results into output memories
    logic [`OUTSIZE-1:0] out_addr;
  } conv_ctrl_t;

  // Element k is row k/3, column k%3
  typedef logic [`FIL_TAPS-1:0][`DWIDTH-1:0] window_t;

endpackage

/* sram.sv */
/* Single-port memory, registered read, no reset on contents.
   A read at the written address returns the old word */
`include "conv_defines.svh"

module sram #(
  parameter int ABITS = 6
) (
  input  logic               clk,
  input  logic               we,
  input  logic [ABITS-1:0]   addr,
  input  logic [`DWIDTH-1:0] wdata,
  output logic [`DWIDTH-1:0] rdata
);

  logic [`DWIDTH-1:0] mem [2**ABITS]; // Depth from address width

  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    rdata <= mem[addr]; // One cycle read latency
  end

endmodule

/* weight_bank.sv */
/* One weight memory per core, all sharing the controller address.
   Host writes land only in the core named by w_wr.core */
`include "conv_defines.svh"

module weight_bank (
  input  logic                            clk,
  input  logic                            reset,
  input  conv_pkg::weight_wr_t            w_wr,
  input  logic [`WSIZE-1:0]               weight_addr,
  output logic [`N_CORE-1:0][`DWIDTH-1:0] rdata
);

  logic [`N_CORE-1:0] core_we; // One-hot write enable

  always_comb begin
    core_we = '0;
    if (w_wr.we && !reset) begin // No stray writes while in reset
      core_we[w_wr.core] = 1'b1;
    end
  end

  for (genvar c = 0; c < `N_CORE; c++) begin : g_mem
    sram #(.ABITS(`WSIZE)) mem_weight (
      .clk   (clk),
      .we    (core_we[c]),
      .addr  (weight_addr), // Host address in idle, tap address otherwise
      .wdata (w_wr.data),
      .rdata (rdata[c])
    );
  end

endmodule

/* line_buf.sv */
/* Pixel shift register of two image rows plus three words. The 3x3 window is
   taken combinationally at offsets set by the runtime img_size */
`include "conv_defines.svh"

module line_buf (
  input  logic               clk,
  input  logic               reset,
  input  logic               buf_en,
  input  logic [`LWIDTH-1:0] img_size,
  input  logic [`DWIDTH-1:0] pixel,
  output conv_pkg::window_t  window
);

  localparam int DEPTH = 2 * `MAX_IMG + 3; // Enough for the widest image

  logic [`DWIDTH-1:0] taps [DEPTH]; // taps[0] is the newest pixel

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int n = 0; n < DEPTH; n++) begin
        taps[n] <= '0;
      end
    end else if (buf_en) begin
      taps[0] <= pixel;
      for (int n = 1; n < DEPTH; n++) begin
        taps[n] <= taps[n-1];
      end
    end
  end

  // Element (i,j) sits (2-i) rows and (2-j) pixels behind the newest
  always_comb begin
    int i;
    int j;
    for (int k = 0; k < `FIL_TAPS; k++) begin
      i = k / `FIL;
      j = k % `FIL;
      window[k] = taps[(2 - i) * int'(img_size) + (2 - j)];
    end
  end

endmodule

/* conv_core.sv */
/* One 3x3 filter core. Taps shift in on wreg_we, tap 0 loaded first.
   Result is ready two cycles after the window, sum shifted by FRAC and wrapped */
`include "conv_defines.svh"

module conv_core (
  input  logic                 clk,
  input  logic                 reset,
  input  conv_pkg::conv_ctrl_t ctrl_bus,
  input  logic [`DWIDTH-1:0]   weight,
  input  conv_pkg::window_t    window,
  output logic [`DWIDTH-1:0]   result
);

  logic [`DWIDTH-1:0]        wreg [`FIL_TAPS]; // Filter registers
  logic signed [`PWIDTH-1:0] prod [`FIL_TAPS]; // Stage one
  logic signed [`PWIDTH-1:0] sum;
  logic signed [`PWIDTH-1:0] scaled;

  // Newest weight enters at the top, so register k ends with tap k
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int k = 0; k < `FIL_TAPS; k++) begin
        wreg[k] <= '0;
      end
    end else if (ctrl_bus.wreg_we) begin
      wreg[`FIL_TAPS-1] <= weight;
      for (int k = 0; k < `FIL_TAPS - 1; k++) begin
        wreg[k] <= wreg[k+1];
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int k = 0; k < `FIL_TAPS; k++) begin
      prod[k] <= $signed(wreg[k]) * $signed(window[k]); // Full width product
    end
  end

  always_comb begin
    sum = '0;
    for (int k = 0; k < `FIL_TAPS; k++) begin
      sum = sum + prod[k]; // Wraps at PWIDTH
    end
    scaled = sum >>> `FRAC; // Arithmetic, keeps sign
  end

  always_ff @(posedge clk) begin
    result <= scaled[`DWIDTH-1:0]; // Stage two, low bits only
  end

endmodule

/* out_bank.sv */
/* Output memories, one per core. The controller write address wins while
   out_we is high. read_output follows out_rd by one cycle */
`include "conv_defines.svh"

module out_bank (
  input  logic                            clk,
  input  logic                            reset,
  input  conv_pkg::conv_ctrl_t            ctrl_bus,
  input  logic [`N_CORE-1:0][`DWIDTH-1:0] result,
  input  conv_pkg::out_rd_t               out_rd,
  output logic [`DWIDTH-1:0]              read_output
);

  logic [`OUTSIZE-1:0]             addr;
  logic [`N_CORE-1:0][`DWIDTH-1:0] rdata;
  logic [`CORE_BITS-1:0]           core_q; // Lines up with read data

  assign addr = ctrl_bus.out_we ? ctrl_bus.out_addr : out_rd.addr;

  always_ff @(posedge clk) begin
    if (reset) begin
      core_q <= '0;
    end else begin
      core_q <= out_rd.core;
    end
  end

  for (genvar c = 0; c < `N_CORE; c++) begin : g_mem
    sram #(.ABITS(`OUTSIZE)) mem_output (
      .clk   (clk),
      .we    (ctrl_bus.out_we), // All cores write together
      .addr  (addr),
      .wdata (result[c]),
      .rdata (rdata[c])
    );
  end

  assign read_output = rdata[core_q];

endmodule

/* conv_ctrl.sv */
/* Layer sequencer: filter load, pixel streaming, result writes, ack.
   img_size is latched at req and must be 3 or more. req outside idle is ignored */
`include "conv_defines.svh"

module conv_ctrl (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 req,
  input  logic [`LWIDTH-1:0]   img_size,
  input  logic [`INSIZE-1:0]   host_in_addr,
  input  logic [`WSIZE-1:0]    host_w_addr,
  output logic [`INSIZE-1:0]   mem_addr,
  output logic [`WSIZE-1:0]    weight_addr,
  output conv_pkg::conv_ctrl_t ctrl_bus,
  output logic                 ack
);

  localparam int LAST_TAP_I = `FIL_TAPS - 1;
  localparam logic [`WSIZE-1:0] LAST_TAP = LAST_TAP_I[`WSIZE-1:0];

  conv_pkg::ctrl_state_e state;
  logic [`LWIDTH-1:0]    size_q;     // Size for this run
  logic [`LWIDTH-1:0]    row;
  logic [`LWIDTH-1:0]    col;
  logic [`WSIZE-1:0]     tap;        // Weight address in load
  logic [`INSIZE-1:0]    pix_addr;   // Raster pixel address
  logic [`OUTSIZE-1:0]   out_cnt;    // Next output word
  logic                  load_q;     // Weight read data valid
  logic                  feed_q;     // Pixel read data valid
  logic [`CONV_LAT-1:0]  valid_pipe; // Windows in flight
  logic                  start;
  logic                  last_col;
  logic                  last_pix;
  logic                  win_valid;

  assign start     = (state == conv_pkg::ST_IDLE) && req;
  assign last_col  = (col == size_q - 1'b1);
  assign last_pix  = last_col && (row == size_q - 1'b1);
  // Row and column of 2 or more, i.e. a full window behind this pixel
  assign win_valid = (state == conv_pkg::ST_FEED) && (row[`LWIDTH-1:1] != '0)
                     && (col[`LWIDTH-1:1] != '0);

  always_ff @(posedge clk) begin
    if (start) begin
      size_q <= img_size;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= conv_pkg::ST_IDLE;
      tap      <= '0;
      row      <= '0;
      col      <= '0;
      pix_addr <= '0;
    end else begin
      case (state)
        conv_pkg::ST_IDLE: begin
          if (req) begin
            state    <= conv_pkg::ST_LOAD;
            tap      <= '0;
            row      <= '0;
            col      <= '0;
            pix_addr <= '0;
          end
        end
        conv_pkg::ST_LOAD: begin
          tap <= tap + 1'b1; // One tap per cycle
          if (tap == LAST_TAP) begin
            state <= conv_pkg::ST_FEED;
          end
        end
        conv_pkg::ST_FEED: begin
          pix_addr <= pix_addr + 1'b1; // One pixel per cycle
          if (last_col) begin
            col <= '0;
            row <= row + 1'b1;
          end else begin
            col <= col + 1'b1;
          end
          if (last_pix) begin
            state <= conv_pkg::ST_DRAIN;
          end
        end
        conv_pkg::ST_DRAIN: begin
          // Only the final stage left, its write lands this cycle
          if (valid_pipe[`CONV_LAT-2:0] == '0) begin
            state <= conv_pkg::ST_DONE;
          end
        end
        conv_pkg::ST_DONE: state <= conv_pkg::ST_IDLE;
        default:           state <= conv_pkg::ST_IDLE;
      endcase
    end
  end

  // Strobes trail the addresses by the memory and datapath latency
  always_ff @(posedge clk) begin
    if (reset) begin
      load_q     <= 1'b0;
      feed_q     <= 1'b0;
      valid_pipe <= '0;
      out_cnt    <= '0;
    end else begin
      load_q     <= (state == conv_pkg::ST_LOAD);
      feed_q     <= (state == conv_pkg::ST_FEED);
      valid_pipe <= {valid_pipe[`CONV_LAT-2:0], win_valid};
      if (start) begin
        out_cnt <= '0;
      end else if (valid_pipe[`CONV_LAT-1]) begin
        out_cnt <= out_cnt + 1'b1; // Raster order of valid windows
      end
    end
  end

  assign mem_addr    = (state == conv_pkg::ST_IDLE) ? host_in_addr : pix_addr;
  assign weight_addr = (state == conv_pkg::ST_IDLE) ? host_w_addr : tap;
  assign ack         = (state == conv_pkg::ST_DONE);

  assign ctrl_bus = '{
    buf_en:   feed_q,
    wreg_we:  load_q,
    out_we:   valid_pipe[`CONV_LAT-1],
    out_addr: out_cnt
  };

endmodule

/* conv_top.sv */
/* Convolution layer top. Host writes and reads only while idle, that is
   before req and after ack. No back-pressure anywhere */
`include "conv_defines.svh"

module conv_top (
  input  logic                 clk,
  input  logic                 reset,
  input  conv_pkg::input_wr_t  in_wr,
  input  conv_pkg::weight_wr_t w_wr,
  input  conv_pkg::out_rd_t    out_rd,
  input  logic [`LWIDTH-1:0]   img_size,
  input  logic                 req,
  output logic                 ack,
  output logic [`DWIDTH-1:0]   read_output
);

  logic [`INSIZE-1:0]              mem_addr;
  logic [`WSIZE-1:0]               weight_addr;
  conv_pkg::conv_ctrl_t            ctrl_bus;
  logic [`DWIDTH-1:0]              pixel;  // Input memory read data
  logic [`N_CORE-1:0][`DWIDTH-1:0] weight; // Per-core tap
  logic [`N_CORE-1:0][`DWIDTH-1:0] result; // Per-core output word
  conv_pkg::window_t               window; // Shared by all cores

  conv_ctrl ctrl (
    .clk          (clk),
    .reset        (reset),
    .req          (req),
    .img_size     (img_size),
    .host_in_addr (in_wr.addr),
    .host_w_addr  (w_wr.addr),
    .mem_addr     (mem_addr),
    .weight_addr  (weight_addr),
    .ctrl_bus     (ctrl_bus),
    .ack          (ack)
  );

  sram #(.ABITS(`INSIZE)) mem_input (
    .clk   (clk),
    .we    (in_wr.we),
    .addr  (mem_addr),
    .wdata (in_wr.data),
    .rdata (pixel)
  );

  weight_bank bank_weight (
    .clk         (clk),
    .reset       (reset),
    .w_wr        (w_wr),
    .weight_addr (weight_addr),
    .rdata       (weight)
  );

  line_buf buf_pix (
    .clk      (clk),
    .reset    (reset),
    .buf_en   (ctrl_bus.buf_en),
    .img_size (img_size),
    .pixel    (pixel),
    .window   (window)
  );

  for (genvar c = 0; c < `N_CORE; c++) begin : g_core
    conv_core core (
      .clk      (clk),
      .reset    (reset),
      .ctrl_bus (ctrl_bus),
      .weight   (weight[c]),
      .window   (window),
      .result   (result[c])
    );
  end

  out_bank bank_output (
    .clk         (clk),
    .reset       (reset),
    .ctrl_bus    (ctrl_bus),
    .result      (result),
    .out_rd      (out_rd),
    .read_output (read_output)
  );

endmodule

/* conv_sva.sv */
/* Controller strobe assertions, bound into every conv_ctrl.
   Checks hold outside reset except the post-reset ack check */
`include "conv_defines.svh"

module conv_sva (
  input logic                  clk,
  input logic                  reset,
  input conv_pkg::ctrl_state_e state,
  input logic                  ack,
  input conv_pkg::conv_ctrl_t  ctrl_bus
);

  ack_one_cycle: assert property (@(posedge clk) disable iff (reset)
    ack |=> !ack)
    else $error("ack stayed high for more than one cycle");

  no_strobe_in_idle: assert property (@(posedge clk) disable iff (reset)
    (state == conv_pkg::ST_IDLE) |-> !(ctrl_bus.out_we || ctrl_bus.wreg_we))
    else $error("out_we or wreg_we high while the controller is idle");

  ack_low_after_reset: assert property (@(posedge clk)
    ($past(reset) && !reset) |-> !ack)
    else $error("ack high in the cycle after reset");

endmodule

bind conv_ctrl conv_sva sva_inst (
  .clk      (clk),
  .reset    (reset),
  .state    (state),
  .ack      (ack),
  .ctrl_bus (ctrl_bus)
);

/* tb_conv_top.sv */
/* Table-driven testbench for conv_top. Pixels are 6-bit LFSR values,
   sign-extended. Each run is checked word by word against a reference model */
`include "conv_defines.svh"

module tb_conv_top;

  localparam int N_RUNS       = 4;
  localparam int ACK_LIMIT    = 400; // Cycles allowed for one run
  localparam int QUIET_CYCLES = 100; // Watch for a stray second ack
  localparam int BUSY_REQ_AT  = 4;   // Extra req lands in ST_LOAD

  localparam int RUN_SIZE [N_RUNS] = '{4, 6, 8, 5};
  localparam int RUN_FILT [N_RUNS][`N_CORE][`FIL_TAPS] = '{
    '{'{0, 0, 0, 0, 256, 0, 0, 0, 0},                      // Center pixel
      '{256, 256, 256, 256, 256, 256, 256, 256, 256}},     // Box sum
    '{'{-256, 0, 256, -512, 0, 512, -256, 0, 256},         // Edge filter
      '{1, -2, 3, -4, 5, -6, 7, -8, 9}},
    '{'{32767, 32767, 32767, 32767, 32767, 32767, 32767, 32767, 32767}, // Overflows
      '{-32768, 12345, -20000, 30000, -1, 777, 32767, -32768, 4096}},
    '{'{128, -128, 64, -64, 32, -32, 16, -16, 8},
      '{-300, 500, -700, 900, -1100, 1300, -1500, 1700, -1900}}
  };

  logic                 clk = 1'b0;
  logic                 reset;
  conv_pkg::input_wr_t  in_wr;
  conv_pkg::weight_wr_t w_wr;
  conv_pkg::out_rd_t    out_rd;
  logic [`LWIDTH-1:0]   img_size;
  logic                 req;
  logic                 ack;
  logic [`DWIDTH-1:0]   read_output;

  logic [31:0] lfsr;            // Pixel source
  int          pix [2**`INSIZE]; // Image of the current run

  conv_top conv_top_inst (
    .clk         (clk),
    .reset       (reset),
    .in_wr       (in_wr),
    .w_wr        (w_wr),
    .out_rd      (out_rd),
    .img_size    (img_size),
    .req         (req),
    .ack         (ack),
    .read_output (read_output)
  );

  always #20 clk = ~clk;

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "testbench stopped on first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic take_pixel(output int value);
    logic [5:0] bits;
    for (int b = 0; b < 6; b++) begin
      lfsr = lfsr_next(lfsr); // One step per bit
      bits = {bits[4:0], lfsr[0]};
    end
    value = int'($signed(bits));
  endtask

  // Sum of filter times window, shifted by FRAC, low DWIDTH bits
  function automatic logic [15:0] model_out(input int run, input int core,
                                            input int r, input int c);
    int          size;
    int          sum;
    logic [31:0] shifted;
    size = RUN_SIZE[run];
    sum  = 0;
    for (int i = 0; i < `FIL; i++) begin
      for (int j = 0; j < `FIL; j++) begin
        sum += RUN_FILT[run][core][i * `FIL + j] * pix[(r - 2 + i) * size + (c - 2 + j)];
      end
    end
    shifted = sum >>> `FRAC;
    return shifted[15:0];
  endfunction

  task automatic load_run(input int run);
    int p;
    int f;
    img_size = RUN_SIZE[run][`LWIDTH-1:0]; // Held for the whole run
    for (int a = 0; a < RUN_SIZE[run] * RUN_SIZE[run]; a++) begin
      @(negedge clk);
      take_pixel(p);
      pix[a]     = p;
      in_wr.we   = 1'b1;
      in_wr.addr = a[`INSIZE-1:0];
      in_wr.data = p[`DWIDTH-1:0];
    end
    for (int c = 0; c < `N_CORE; c++) begin
      for (int k = 0; k < `FIL_TAPS; k++) begin
        @(negedge clk);
        f         = RUN_FILT[run][c][k];
        in_wr.we  = 1'b0;
        w_wr.we   = 1'b1;
        w_wr.core = c[`CORE_BITS-1:0];
        w_wr.addr = k[`WSIZE-1:0];
        w_wr.data = f[`DWIDTH-1:0];
      end
    end
    @(negedge clk);
    w_wr.we = 1'b0;
  endtask

  // One req, one ignored req while busy, exactly one ack
  task automatic run_layer();
    int acks;
    int cycles;
    acks   = 0;
    cycles = 0;
    @(negedge clk);
    req = 1'b1;
    while (acks == 0) begin
      @(negedge clk);
      cycles++;
      req = (cycles == BUSY_REQ_AT);
      if (ack) begin
        acks++;
      end
      if (cycles > ACK_LIMIT) begin
        stop_with_failure("Timeout: the DUT never raised ack after req");
      end
    end
    for (int n = 0; n < QUIET_CYCLES; n++) begin
      @(negedge clk);
      if (ack) begin
        acks++;
      end
    end
    check_value("ack count", acks, 1);
  endtask

  task automatic check_outputs(input int run);
    int size;
    int addr;
    size = RUN_SIZE[run];
    for (int core = 0; core < `N_CORE; core++) begin
      for (int r = 2; r < size; r++) begin
        for (int c = 2; c < size; c++) begin
          addr = (r - 2) * (size - 2) + (c - 2); // Raster order of valid windows
          @(negedge clk);
          out_rd.core = core[`CORE_BITS-1:0];
          out_rd.addr = addr[`OUTSIZE-1:0];
          @(negedge clk); // One cycle read latency
          check_value($sformatf("read_output core %0d addr %0d", core, addr),
                      read_output, model_out(run, core, r, c));
        end
      end
    end
  endtask

  initial begin
    reset    = 1'b1;
    req      = 1'b0;
    img_size = '0;
    in_wr    = '0;
    w_wr     = '0;
    out_rd   = '0;
    lfsr     = 32'hd83f;
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    for (int n = 0; n < 8; n++) begin // No ack before the first req
      @(negedge clk);
      check_value("ack", ack, 0);
    end
    for (int run = 0; run < N_RUNS; run++) begin
      $display("Run %0d, img_size %0d", run, RUN_SIZE[run]);
      load_run(run);
      run_layer();
      check_outputs(run);
    end
    $display("STATUS: PASS");
    $finish;
  end

endmodule

/* tb.f */
+incdir+.
conv_pkg.sv
sram.sv
weight_bank.sv
line_buf.sv
conv_core.sv
out_bank.sv
conv_ctrl.sv
conv_top.sv
conv_sva.sv
tb_conv_top.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_conv_top -f tb.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed"
  exit $status
fi

./obj_dir/Vtb_conv_top
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed"
  exit $status
fi
exit 0
